/* source/sd_decimator_pkg.sv */
// Shared constants for the four-channel sigma-delta decimator
// Widths, ratios and channel count used across the datapath

package sd_decimator_pkg;

    // Number of external modulator inputs
    localparam int num_channels = 4;

    // System clocks per modulator clock period, kept even for a 50% duty cycle
    localparam int mod_div = 4;

    // Modulator bits per decimated output sample
    localparam int decimation = 16;

    // Number of integrator stages, and the same number of comb stages
    localparam int cic_order = 3;

    // Accumulator width is log2(R) * N + 1, all filter arithmetic wraps at this width
    localparam int cic_width = $clog2(decimation) * cic_order + 1;

    // Signed width of the samples handed out by the collector
    localparam int sample_width = 13;

    // Filter DC gain is R to the power N, so all ones gives this value
    localparam int full_scale = decimation ** cic_order;

    // Offset that centres the unsigned filter output around zero
    localparam logic [cic_width-1:0] midscale = cic_width'(full_scale / 2);

    // Width of the channel number on the output
    localparam int channel_index_width = $clog2(num_channels);

    // Counter widths for the modulator clock divider and the decimation counter
    localparam int mod_count_width = $clog2(mod_div);
    localparam int dec_count_width = $clog2(decimation);

endpackage

/* source/sd_timing.sv */
// Modulator clock and tick generator
// Makes sd_clock, the per-bit mod_tick and the per-sample dec_tick

`timescale 1ns/1ps

module sd_timing (
    input  logic clock,
    input  logic rst_n,
    input  logic run,
    output logic sd_clock,
    output logic mod_tick,
    output logic dec_tick
);

    localparam int mw = sd_decimator_pkg::mod_count_width;
    localparam int dw = sd_decimator_pkg::dec_count_width;

    // Last count of a modulator period, where sd_clock rises again
    localparam logic [mw-1:0] period_last = mw'(sd_decimator_pkg::mod_div - 1);
    // Count after which the high half of the period ends
    localparam logic [mw-1:0] high_last = mw'(sd_decimator_pkg::mod_div / 2 - 1);
    // Last modulator bit of a decimation period
    localparam logic [dw-1:0] dec_last = dw'(sd_decimator_pkg::decimation - 1);

    logic [mw-1:0] div_count;
    logic [dw-1:0] dec_count;
    logic period_end;
    logic dec_end;

    assign period_end = (div_count == period_last);
    assign dec_end = (dec_count == dec_last);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            div_count <= '0;
            dec_count <= '0;
            sd_clock  <= 1'b0;
            mod_tick  <= 1'b0;
            dec_tick  <= 1'b0;
        end else begin
            // Ticks are single-cycle strobes by default
            mod_tick <= 1'b0;
            dec_tick <= 1'b0;
            if (!run) begin
                // Counters freeze and the modulator clock is parked low
                sd_clock <= 1'b0;
            end else begin
                div_count <= period_end ? '0 : div_count + 1'b1;
                if (period_end) begin
                    // Rising edge of sd_clock, the channels sample in this same cycle
                    sd_clock  <= 1'b1;
                    mod_tick  <= 1'b1;
                    dec_count <= dec_end ? '0 : dec_count + 1'b1;
                    dec_tick  <= dec_end;
                end else if (div_count == high_last) begin
                    // Modulators shift out their next bit after this falling edge
                    sd_clock <= 1'b0;
                end
            end
        end
    end

endmodule

/* source/sd_cic_channel.sv */
// One third-order CIC decimation channel
// Integrates the modulator bit stream and emits a mid-scale centred sample

`timescale 1ns/1ps

module sd_cic_channel (
    input  logic clock,
    input  logic rst_n,
    input  logic sd_data,
    input  logic mod_tick,
    input  logic dec_tick,
    output logic signed [sd_decimator_pkg::sample_width-1:0] sample,
    output logic sample_ready
);

    localparam int w = sd_decimator_pkg::cic_width;
    localparam int n = sd_decimator_pkg::cic_order;

    // Integrator chain, stage 0 takes the raw bit
    logic [w-1:0] integ [n];

    // Previous comb inputs, one per comb stage
    logic [w-1:0] comb_delay [n];

    // Comb differences, valid in the dec_tick cycle
    logic [w-1:0] comb [n];

    // Final comb value with the mid-scale offset removed
    logic [w-1:0] centred;

    // Integrators advance once per modulator bit
    // Each stage adds the registered output of the one before it
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < n; i++) begin
                integ[i] <= '0;
            end
        end else if (mod_tick) begin
            integ[0] <= integ[0] + {{(w-1){1'b0}}, sd_data};
            for (int i = 1; i < n; i++) begin
                integ[i] <= integ[i] + integ[i-1];
            end
        end
    end

    // Comb chain runs at the decimated rate on the last integrator output
    always_comb begin
        comb[0] = integ[n-1] - comb_delay[0];
        for (int i = 1; i < n; i++) begin
            comb[i] = comb[i-1] - comb_delay[i];
        end
    end

    // Store this period's comb inputs for the next decimation tick
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < n; i++) begin
                comb_delay[i] <= '0;
            end
        end else if (dec_tick) begin
            comb_delay[0] <= integ[n-1];
            for (int i = 1; i < n; i++) begin
                comb_delay[i] <= comb[i-1];
            end
        end
    end

    // Wrapping subtraction gives the two's complement sample directly
    // since the filter output never exceeds full scale
    assign centred = comb[n-1] - sd_decimator_pkg::midscale;

    // Output stage, the sample appears one cycle after dec_tick
    always_ff @(posedge clock) begin
        if (dec_tick) begin
            sample <= $signed(centred);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= dec_tick;
        end
    end

endmodule

/* source/sample_collector.sv */
// Output collector for the decimated channels
// Latches a set of samples and hands them out one unmasked channel per cycle

`timescale 1ns/1ps

module sample_collector (
    input  logic clock,
    input  logic rst_n,
    input  logic [sd_decimator_pkg::num_channels-1:0][sd_decimator_pkg::sample_width-1:0]
        channel_samples,
    input  logic sample_ready,
    input  logic [sd_decimator_pkg::num_channels-1:0] channel_mask,
    output logic sample_valid,
    output logic [sd_decimator_pkg::channel_index_width-1:0] sample_channel,
    output logic signed [sd_decimator_pkg::sample_width-1:0] sample_data
);

    localparam int nc = sd_decimator_pkg::num_channels;
    localparam int sw = sd_decimator_pkg::sample_width;
    localparam int iw = sd_decimator_pkg::channel_index_width;

    // Samples of the current burst, held until the next sample_ready
    logic [nc-1:0][sw-1:0] held_samples;

    // Channels of this burst that are still to be sent
    logic [nc-1:0] pending;

    // Lowest pending channel as index and as one-hot bit
    logic [iw-1:0] next_channel;
    logic [nc-1:0] lowest_bit;
    logic found;

    // Priority pick of the lowest pending channel keeps ascending order
    always_comb begin
        found = 1'b0;
        next_channel = '0;
        lowest_bit = '0;
        for (int i = 0; i < nc; i++) begin
            if (pending[i] && !found) begin
                found = 1'b1;
                next_channel = iw'(i);
                lowest_bit[i] = 1'b1;
            end
        end
    end

    // The mask is captured with the samples, so a change mid-burst waits for the next one
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (sample_ready) begin
            pending <= channel_mask;
        end else begin
            pending <= pending & ~lowest_bit;
        end
    end

    always_ff @(posedge clock) begin
        if (sample_ready) begin
            held_samples <= channel_samples;
        end
    end

    // One channel leaves per cycle while any is pending
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= found;
        end
    end

    always_ff @(posedge clock) begin
        if (found) begin
            sample_channel <= next_channel;
            sample_data <= $signed(held_samples[next_channel]);
        end
    end

endmodule

/* source/sd_decimator_top.sv */
// Four-channel sigma-delta decimator top level
// Joins the timing block, the CIC channels and the output collector

`timescale 1ns/1ps

module sd_decimator_top (
    input  logic clock,
    input  logic rst_n,
    input  logic run,
    input  logic [sd_decimator_pkg::num_channels-1:0] channel_mask,
    input  logic [sd_decimator_pkg::num_channels-1:0] sd_data,
    output logic sd_clock,
    output logic sample_valid,
    output logic [sd_decimator_pkg::channel_index_width-1:0] sample_channel,
    output logic signed [sd_decimator_pkg::sample_width-1:0] sample_data
);

    localparam int nc = sd_decimator_pkg::num_channels;
    localparam int sw = sd_decimator_pkg::sample_width;

    logic mod_tick;
    logic dec_tick;

    // All channel outputs side by side for the collector
    logic [nc-1:0][sw-1:0] channel_samples;
    logic [nc-1:0] channel_ready;

    sd_timing timing (
        .clock    (clock),
        .rst_n    (rst_n),
        .run      (run),
        .sd_clock (sd_clock),
        .mod_tick (mod_tick),
        .dec_tick (dec_tick)
    );

    // Identical filters, one per modulator input
    for (genvar ch = 0; ch < nc; ch++) begin : g_channel
        sd_cic_channel channel (
            .clock        (clock),
            .rst_n        (rst_n),
            .sd_data      (sd_data[ch]),
            .mod_tick     (mod_tick),
            .dec_tick     (dec_tick),
            .sample       (channel_samples[ch]),
            .sample_ready (channel_ready[ch])
        );
    end

    // Every channel runs on the same ticks, so channel 0's strobe stands for all of them
    sample_collector collector (
        .clock           (clock),
        .rst_n           (rst_n),
        .channel_samples (channel_samples),
        .sample_ready    (channel_ready[0]),
        .channel_mask    (channel_mask),
        .sample_valid    (sample_valid),
        .sample_channel  (sample_channel),
        .sample_data     (sample_data)
    );

endmodule

/* bench/clock_source.sv */
// Testbench clock and reset source
// 40 ns clock with rst_n held low for the first 5 cycles

`timescale 1ns/1ps

module clock_source (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Reset leaves on a falling edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

/* bench/sd_decimator_tb.sv */
// Directed testbench for the four-channel sigma-delta decimator
// Models the modulators and checks every sample burst the collector emits

`timescale 1ns/1ps

module sd_decimator_tb;

    localparam int nc = sd_decimator_pkg::num_channels;
    // System clocks per decimated sample
    localparam int period_clocks = sd_decimator_pkg::mod_div * sd_decimator_pkg::decimation;
    // Sample periods used by the five tests in order
    localparam int test_periods = 4 + 7 + 7 + 9 + 7;
    localparam int watchdog_clocks = test_periods * period_clocks * 2;

    logic clock;
    logic rst_n;
    logic run;
    logic [nc-1:0] channel_mask;
    logic [nc-1:0] sd_data;
    logic sd_clock;
    logic sample_valid;
    logic [sd_decimator_pkg::channel_index_width-1:0] sample_channel;
    logic signed [sd_decimator_pkg::sample_width-1:0] sample_data;

    // Modulator models share one bit position that steps on each sd_clock fall
    logic [15:0] patterns [nc];
    logic [3:0] bit_pos;
    logic sd_clock_prev;

    logic signed [31:0] expected_value [nc];
    logic signed [31:0] burst_value [nc];
    int burst_channel [nc];
    int burst_count;
    int error_count;
    int check_count;
    logic [31:0] lfsr_state;

    clock_source clocks (
        .clock (clock),
        .rst_n (rst_n)
    );

    sd_decimator_top UUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .run            (run),
        .channel_mask   (channel_mask),
        .sd_data        (sd_data),
        .sd_clock       (sd_clock),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data)
    );

    always_comb begin
        for (int ch = 0; ch < nc; ch++) begin
            sd_data[ch] = patterns[ch][bit_pos];
        end
    end

    // A fall of sd_clock shows up at the next falling clock edge
    always @(negedge clock) begin
        if (sd_clock_prev && !sd_clock) begin
            bit_pos <= bit_pos + 4'd1;
        end
        sd_clock_prev <= sd_clock;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int ones_count(input logic [15:0] pattern);
        int total;
        total = 0;
        for (int b = 0; b < 16; b++) begin
            total += int'(pattern[b]);
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("** Error at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Waits for the next burst and records it until sample_valid drops
    task automatic collect_burst();
        int waited;
        waited = 0;
        burst_count = 0;
        while (!sample_valid && waited < period_clocks + 8) begin
            @(negedge clock);
            waited++;
        end
        if (!sample_valid) begin
            $display("Timeout at %0d ns: no sample burst arrived within %0d clocks",
                     $time, waited);
            error_count++;
        end
        while (sample_valid) begin
            if (burst_count < nc) begin
                burst_channel[burst_count] = int'(sample_channel);
                burst_value[burst_count] = 32'(sample_data);
            end
            burst_count++;
            @(negedge clock);
        end
    endtask

    task automatic skip_bursts(input int count);
        repeat (count) collect_burst();
    endtask

    // Unmasked channels must arrive in ascending order with their expected values
    task automatic check_burst(input logic [nc-1:0] mask);
        int k;
        k = 0;
        collect_burst();
        for (int ch = 0; ch < nc; ch++) begin
            if (mask[ch]) begin
                if (k < burst_count) begin
                    check_value("sample_channel", ch, burst_channel[k]);
                    check_value("sample_data", expected_value[ch], burst_value[k]);
                end
                k++;
            end
        end
        check_value("burst length", k, burst_count);
    endtask

    // The modulator clock only parks low while run is low
    task automatic watch_quiet(input int clocks, input logic check_sd_clock);
        repeat (clocks) begin
            if (check_sd_clock) begin
                check_value("sd_clock", 0, 32'(sd_clock));
            end
            check_value("sample_valid", 0, 32'(sample_valid));
            @(negedge clock);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%0d ns: %s passed", $time, name);
        end else begin
            $display("%0d ns: %s failed with %0d errors", $time, name,
                     error_count - errors_before);
        end
    endtask

    task automatic quiet_after_reset();
        int errors_before;
        errors_before = error_count;
        watch_quiet(200, 1'b1);
        finish_test("quiet_after_reset", errors_before);
    endtask

    task automatic constant_densities();
        int errors_before;
        errors_before = error_count;
        // All ones, all zeros, one in two and one in four
        patterns[0] = 16'hffff;
        patterns[1] = 16'h0000;
        patterns[2] = 16'haaaa;
        patterns[3] = 16'h8888;
        expected_value[0] = 2048;
        expected_value[1] = -2048;
        expected_value[2] = 0;
        expected_value[3] = -1024;
        channel_mask = 4'b1111;
        run = 1'b1;
        skip_bursts(3);
        repeat (4) check_burst(4'b1111);
        finish_test("constant_densities", errors_before);
    endtask

    task automatic mask_selection();
        int errors_before;
        errors_before = error_count;
        // Each mask change lands between bursts so the next burst takes it
        collect_burst();
        channel_mask = 4'b1010;
        repeat (3) check_burst(4'b1010);
        channel_mask = 4'b0000;
        watch_quiet(3 * period_clocks, 1'b0);
        channel_mask = 4'b1111;
        finish_test("mask_selection", errors_before);
    endtask

    task automatic run_gating();
        int errors_before;
        errors_before = error_count;
        collect_burst();
        run = 1'b0;
        // sd_clock may still be high for one cycle before it parks low
        @(negedge clock);
        watch_quiet(3 * period_clocks, 1'b1);
        run = 1'b1;
        skip_bursts(3);
        repeat (2) check_burst(4'b1111);
        finish_test("run_gating", errors_before);
    endtask

    task automatic random_patterns();
        int errors_before;
        errors_before = error_count;
        for (int ch = 0; ch < nc; ch++) begin
            for (int b = 0; b < 16; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                patterns[ch][b] = lfsr_state[0];
            end
            // Each one in the 16-bit period adds 256 to the sample
            expected_value[ch] = 256 * ones_count(patterns[ch]) - 2048;
        end
        skip_bursts(3);
        repeat (4) check_burst(4'b1111);
        finish_test("random_patterns", errors_before);
    endtask

    initial begin
        repeat (watchdog_clocks) @(posedge clock);
        $display("Watchdog expired after %0d clocks, the tests did not finish", watchdog_clocks);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        run = 1'b0;
        channel_mask = '0;
        bit_pos <= '0;
        sd_clock_prev <= 1'b0;
        error_count = 0;
        check_count = 0;
        lfsr_state = 32'hcde8d672;
        for (int ch = 0; ch < nc; ch++) begin
            patterns[ch] = '0;
            expected_value[ch] = 0;
        end
        wait (rst_n === 1'b1);
        @(negedge clock);
        quiet_after_reset();
        constant_densities();
        mask_selection();
        run_gating();
        random_patterns();
        $display("Summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/sd_decimator_pkg.sv
source/sd_timing.sv
source/sd_cic_channel.sv
source/sample_collector.sv
source/sd_decimator_top.sv
bench/clock_source.sv
bench/sd_decimator_tb.sv

/* Makefile */
# Verilator build and run for the sigma-delta decimator testbench

VERILATOR ?= verilator
TOP       ?= sd_decimator_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= Test OK

SIM = $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# The run fails unless the pass line appears in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
